/* rtl/aout_pkg.sv */
/*
 * Audio output shared definitions: widths, register offsets,
 * control and status structs, and the APB write-word union
 */

`default_nettype none

package aout_pkg;

    // ------------------------------------------------------------------
    // Widths

    localparam int sample_w    = 16;
    localparam int pwm_bits    = 8;     // Duty bits, one period is 256 cycles
    localparam int interval_w  = 8;
    localparam int irq_level_w = 4;
    localparam int apb_addr_w  = 4;

    // ------------------------------------------------------------------
    // Register map

    localparam logic [apb_addr_w-1:0] csr_offset  = 4'h0;
    localparam logic [apb_addr_w-1:0] fifo_offset = 4'h4;

    // ------------------------------------------------------------------
    // Register layouts

    // Control view of a write word, LSB field last
    typedef struct packed {
        logic [7:0]             spare_hi;
        logic [interval_w-1:0]  interval;
        logic [irq_level_w-1:0] irq_level;
        logic [9:0]             spare_lo;
        logic                   signed_fmt;
        logic                   enable;
    } aout_ctrl_t;

    // Sample view of a write word
    typedef struct packed {
        logic [15:0]         spare;
        logic [sample_w-1:0] sample;
    } aout_sample_t;

    // Same APB word, decoded by address
    typedef union packed {
        aout_ctrl_t   ctrl;
        aout_sample_t smp;
    } aout_wdata_u;

    // Status byte, placed in bits 31:24 of a control read
    typedef struct packed {
        logic       running;
        logic       fifo_full;
        logic [5:0] level;
    } aout_status_t;

endpackage

`default_nettype wire

/* rtl/aout_apb_regs.sv */
/*
 * APB slave for the audio output: control register, sample push
 * with back-pressure while the FIFO is full, and status readback
 */

`timescale 1ns/10ps
`default_nettype none

module aout_apb_regs
    import aout_pkg::*;
#(
    parameter int fifo_addr_w = 2
) (
    input  logic                  clk_sys,
    input  logic                  rst_n_sys,

    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_addr_w-1:0] paddr,
    input  aout_wdata_u           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,

    input  logic                  fifo_full,
    input  logic [fifo_addr_w:0]  fifo_level,
    input  logic                  running,

    output aout_ctrl_t            ctrl,
    output logic                  push,
    output logic [sample_w-1:0]   push_sample
);

    logic         csr_hit;
    logic         fifo_hit;
    logic         access;
    logic         csr_wr;
    aout_status_t status;

    // ------------------------------------------------------------------
    // Address decode and handshake

    assign csr_hit  = (paddr == csr_offset);
    assign fifo_hit = (paddr == fifo_offset);
    assign access   = psel && penable;

    // Sample writes wait here until the FIFO has room
    assign pready  = !(psel && pwrite && fifo_hit && fifo_full);
    assign pslverr = access && !(csr_hit || fifo_hit);

    assign csr_wr = access && pwrite && csr_hit;

    // Push lands in the completing access cycle
    assign push        = access && pwrite && fifo_hit && !fifo_full;
    assign push_sample = pwdata.smp.sample;

    // ------------------------------------------------------------------
    // Control register

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            ctrl <= '0;
        end else if (csr_wr) begin
            ctrl.enable     <= pwdata.ctrl.enable;
            ctrl.signed_fmt <= pwdata.ctrl.signed_fmt;
            ctrl.irq_level  <= pwdata.ctrl.irq_level;
            ctrl.interval   <= pwdata.ctrl.interval;
            // Spare fields always read back as zero
            ctrl.spare_lo   <= '0;
            ctrl.spare_hi   <= '0;
        end
    end

    // ------------------------------------------------------------------
    // Read data

    always_comb begin
        status.running   = running;
        status.fifo_full = fifo_full;
        status.level     = 6'(fifo_level);
    end

    always_comb begin
        prdata = '0;
        if (psel && !pwrite && csr_hit) begin
            prdata = {status, ctrl.interval, ctrl.irq_level, ctrl.spare_lo,
                      ctrl.signed_fmt, ctrl.enable};
        end
    end

    // ------------------------------------------------------------------
    // Checks

    // The FIFO never sees a push it cannot store
    push_not_full: assert property (
        @(posedge clk_sys) disable iff (!rst_n_sys)
        push |-> (int'(fifo_level) < 2 ** fifo_addr_w)
    );

    // Software must stop playback before changing the repeat interval
    interval_stable: assert property (
        @(posedge clk_sys) disable iff (!rst_n_sys)
        running |=> $stable(ctrl.interval)
    );

endmodule

`default_nettype wire

/* rtl/aout_sample_fifo.sv */
/*
 * Synchronous sample FIFO with sign conversion on entry,
 * level count and level interrupt
 */

`timescale 1ns/10ps
`default_nettype none

module aout_sample_fifo
    import aout_pkg::*;
#(
    parameter int fifo_addr_w = 2
) (
    input  logic                   clk_sys,
    input  logic                   rst_n_sys,

    input  logic                   push,
    input  logic [sample_w-1:0]    push_sample,
    input  logic                   signed_fmt,
    input  logic [irq_level_w-1:0] irq_level,

    input  logic                   pop,
    output logic                   rd_valid,
    output logic [sample_w-1:0]    rd_sample,

    output logic                   full,
    output logic [fifo_addr_w:0]   level,
    output logic                   irq
);

    localparam int depth = 2 ** fifo_addr_w;
    localparam logic [sample_w-1:0] sign_mask = {1'b1, {(sample_w-1){1'b0}}};

    logic [sample_w-1:0]    mem [depth];
    logic [fifo_addr_w-1:0] wr_ptr;
    logic [fifo_addr_w-1:0] rd_ptr;
    logic [sample_w-1:0]    wr_data;

    // ------------------------------------------------------------------
    // Storage

    // Signed samples become offset binary here, so the PWM stage
    // only ever sees unsigned values
    assign wr_data = push_sample ^ (signed_fmt ? sign_mask : '0);

    always_ff @(posedge clk_sys) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    assign rd_sample = mem[rd_ptr];

    // ------------------------------------------------------------------
    // Pointers and level

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    assign rd_valid = (level != '0);

    // Level only reaches depth when full, so the top bit is the flag
    assign full = level[fifo_addr_w];

    // Level interrupt, high at or below the threshold
    assign irq = ({{irq_level_w{1'b0}}, level} <= {{(fifo_addr_w+1){1'b0}}, irq_level});

    // ------------------------------------------------------------------
    // Checks

    pop_needs_valid: assert property (
        @(posedge clk_sys) disable iff (!rst_n_sys)
        pop |-> rd_valid
    );

endmodule

`default_nettype wire

/* rtl/aout_pwm.sv */
/*
 * Repeat-interval sequencer and PWM modulator driving the audio pin
 */

`timescale 1ns/10ps
`default_nettype none

module aout_pwm
    import aout_pkg::*;
(
    input  logic                  clk_sys,
    input  logic                  rst_n_sys,

    input  logic                  enable,
    input  logic [interval_w-1:0] interval,

    input  logic                  rd_valid,
    input  logic [sample_w-1:0]   rd_sample,
    output logic                  pop,

    output logic                  running,
    output logic                  audio
);

    logic [pwm_bits-1:0]   period_cnt;
    logic [interval_w-1:0] hold_cnt;
    logic [pwm_bits-1:0]   duty_q;
    logic                  have_q;

    logic                  boundary;
    logic                  need_new;
    logic                  load;
    logic [pwm_bits-1:0]   duty_now;
    logic                  have_now;

    // ------------------------------------------------------------------
    // Sequencer

    assign boundary = enable && (period_cnt == '0);

    // Current sample has had interval + 1 periods, or there is none
    assign need_new = !have_q || (hold_cnt == interval);
    assign load     = boundary && need_new;
    assign pop      = load && rd_valid;

    // Duty in force for this cycle, including a sample loaded right now
    always_comb begin
        duty_now = duty_q;
        have_now = have_q;
        if (load) begin
            have_now = rd_valid;
            duty_now = rd_valid ? rd_sample[sample_w-1 -: pwm_bits] : '0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (load) begin
            duty_q <= duty_now;
        end
    end

    // ------------------------------------------------------------------
    // Counters and output

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            period_cnt <= '0;
            hold_cnt   <= '0;
            have_q     <= 1'b0;
            audio      <= 1'b0;
        end else if (!enable) begin
            period_cnt <= '0;
            hold_cnt   <= '0;
            have_q     <= 1'b0;
            audio      <= 1'b0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
            have_q     <= have_now;
            if (load) begin
                hold_cnt <= '0;
            end else if (boundary) begin
                hold_cnt <= hold_cnt + 1'b1;
            end
            // Registered, so each period gives exactly duty high cycles
            audio <= have_now && (period_cnt < duty_now);
        end
    end

    assign running = have_q;

endmodule

`default_nettype wire

/* rtl/aout_top.sv */
/*
 * Audio output top level: APB registers, sample FIFO and PWM stage
 */

`timescale 1ns/10ps
`default_nettype none

module aout_top
    import aout_pkg::*;
#(
    parameter int fifo_addr_w = 2
) (
    input  logic                  clk_sys,
    input  logic                  rst_n_sys,

    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_addr_w-1:0] paddr,
    input  aout_wdata_u           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,

    output logic                  irq_aout,
    output logic                  audio
);

    aout_ctrl_t            ctrl;
    logic                  push;
    logic [sample_w-1:0]   push_sample;
    logic                  fifo_full;
    logic [fifo_addr_w:0]  fifo_level;
    logic                  rd_valid;
    logic [sample_w-1:0]   rd_sample;
    logic                  pop;
    logic                  running;

    aout_apb_regs #(
        .fifo_addr_w (fifo_addr_w)
    ) aout_apb_regs_i (
        .clk_sys     (clk_sys),
        .rst_n_sys   (rst_n_sys),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .fifo_full   (fifo_full),
        .fifo_level  (fifo_level),
        .running     (running),
        .ctrl        (ctrl),
        .push        (push),
        .push_sample (push_sample)
    );

    aout_sample_fifo #(
        .fifo_addr_w (fifo_addr_w)
    ) aout_sample_fifo_i (
        .clk_sys     (clk_sys),
        .rst_n_sys   (rst_n_sys),
        .push        (push),
        .push_sample (push_sample),
        .signed_fmt  (ctrl.signed_fmt),
        .irq_level   (ctrl.irq_level),
        .pop         (pop),
        .rd_valid    (rd_valid),
        .rd_sample   (rd_sample),
        .full        (fifo_full),
        .level       (fifo_level),
        .irq         (irq_aout)
    );

    aout_pwm aout_pwm_i (
        .clk_sys     (clk_sys),
        .rst_n_sys   (rst_n_sys),
        .enable      (ctrl.enable),
        .interval    (ctrl.interval),
        .rd_valid    (rd_valid),
        .rd_sample   (rd_sample),
        .pop         (pop),
        .running     (running),
        .audio       (audio)
    );

endmodule

`default_nettype wire

/* verification/tb_aout.sv */
/*
 * Testbench for the audio output block: runs the operations in the
 * input file over APB and checks reads, IRQ, FIFO stalls and audio
 */

`timescale 1ns/10ps
`default_nettype none

module tb_aout
    import aout_pkg::*;
();

    localparam int    fifo_addr_w   = 2;
    localparam int    clk_period    = 100;
    localparam int    margin_cycles = 2000;
    localparam string input_path    = "verification/aout_input.txt";

    logic                  clk_sys;
    logic                  rst_n_sys;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    aout_wdata_u           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  irq_aout;
    logic                  audio;

    // Operations read from the input file
    string       op_name[$];
    string       op_kind[$];
    logic [31:0] op_addr[$];
    logic [31:0] op_data[$];
    logic [31:0] op_expect[$];

    int tests_run    = 0;
    int tests_failed = 0;
    int error_count  = 0;
    bit test_bad     = 1'b0;
    int high_cycles  = 0;
    int high_base    = 0;
    int cycle_count  = 0;
    int cycle_limit  = 0;

    // Reference model of the sample path
    bit model_signed   = 1'b0;
    int model_interval = 0;
    int exp_duty[$];
    int pulse_widths[$];
    int run_len        = 0;

    aout_top #(
        .fifo_addr_w (fifo_addr_w)
    ) aout_top_i (
        .clk_sys   (clk_sys),
        .rst_n_sys (rst_n_sys),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .irq_aout  (irq_aout),
        .audio     (audio)
    );

    initial begin
        clk_sys = 1'b0;
        forever #(clk_period / 2) clk_sys = ~clk_sys;
    end

    // Audio is registered, so it is steady at the falling edge
    always @(negedge clk_sys) begin
        if (audio) begin
            high_cycles++;
            run_len++;
        end else if (run_len > 0) begin
            pulse_widths.push_back(run_len);
            run_len = 0;
        end
    end

    // Duty of a sample: its top byte, sign bit flipped for signed format
    function automatic int sample_duty(input logic [31:0] data, input bit signed_fmt);
        logic [7:0] top;
        top = data[15:8];
        if (signed_fmt) begin
            top[7] = ~top[7];
        end
        return int'(top);
    endfunction

    // ------------------------------------------------------------------
    // Reporting

    task automatic report_value(input string name, input string what,
                                input logic [31:0] expect_val, input logic [31:0] actual);
        $display("ERROR %s: %s expected %h, actual %h", name, what, expect_val, actual);
        error_count++;
        test_bad = 1'b1;
    endtask

    task automatic report_problem(input string name, input string msg);
        $display("FAILED %s: %s", name, msg);
        error_count++;
        test_bad = 1'b1;
    endtask

    // ------------------------------------------------------------------
    // APB master, called and returning at a falling edge

    task automatic apb_transfer(input logic wr, input logic [31:0] addr,
                                input logic [31:0] data, output logic [31:0] rdata,
                                output logic err, output int waits);
        logic done;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr[apb_addr_w-1:0];
        pwdata  = data;
        waits   = 0;
        done    = 1'b0;
        rdata   = '0;
        err     = 1'b0;
        @(negedge clk_sys);
        penable = 1'b1;
        while (!done) begin
            // Mid cycle, clear of both edges
            #(clk_period / 4);
            done  = pready;
            rdata = prdata;
            err   = pslverr;
            @(negedge clk_sys);
            if (!done) begin
                waits++;
            end
        end
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Input file

    task automatic load_ops(output bit ok);
        int          fd;
        int          n;
        int          samples;
        logic [7:0]  max_interval;
        string       line;
        string       name;
        string       kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expect_val;
        ok           = 1'b0;
        samples      = 0;
        max_interval = '0;
        fd = $fopen(input_path, "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %s %h %h %h", name, kind, addr, data, expect_val);
            if (n != 5) begin
                $display("Skipping a line of %s that has too few columns", input_path);
                continue;
            end
            op_name.push_back(name);
            op_kind.push_back(kind);
            op_addr.push_back(addr);
            op_data.push_back(data);
            op_expect.push_back(expect_val);
            // Interval field sits in bits 23:16 of the control word
            if (kind == "wr" && addr[3:0] == 4'h0 && data[23:16] > max_interval) begin
                max_interval = data[23:16];
            end
            if (kind == "wr" && addr[3:0] == 4'h4) begin
                samples++;
            end
            if (kind == "fill") begin
                samples += 2 ** fifo_addr_w;
            end
        end
        $fclose(fd);
        // One PWM period is 256 cycles, each sample lasts interval + 1 periods
        cycle_limit = samples * 256 * (int'(max_interval) + 1) + margin_cycles;
        ok = (op_name.size() > 0);
    endtask

    // ------------------------------------------------------------------
    // One operation

    task automatic run_op(input int i);
        string       name;
        string       kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expect_val;
        logic [31:0] rdata;
        logic        err;
        logic        err_expect;
        int          waits;
        int          tries;
        int          total;
        int          exp_pulses[$];
        bit          pulse_bad;
        name       = op_name[i];
        kind       = op_kind[i];
        addr       = op_addr[i];
        data       = op_data[i];
        expect_val = op_expect[i];
        test_bad   = 1'b0;
        // Only offsets 0 and 4 are mapped
        err_expect = (addr[3:0] != 4'h0) && (addr[3:0] != 4'h4);

        if (kind == "wr") begin
            apb_transfer(1'b1, addr, data, rdata, err, waits);
            if (err !== err_expect) begin
                report_value(name, "pslverr", 32'(err_expect), 32'(err));
            end
            if (addr[3:0] == 4'h0) begin
                model_signed   = data[1];
                model_interval = int'(data[23:16]);
            end else if (addr[3:0] == 4'h4) begin
                exp_duty.push_back(sample_duty(data, model_signed));
            end
        end else if (kind == "rd") begin
            apb_transfer(1'b0, addr, 32'h0, rdata, err, waits);
            if (rdata !== expect_val) begin
                report_value(name, "prdata", expect_val, rdata);
            end
            if (err !== err_expect) begin
                report_value(name, "pslverr", 32'(err_expect), 32'(err));
            end
        end else if (kind == "irq") begin
            if (irq_aout !== expect_val[0]) begin
                report_value(name, "irq_aout", expect_val, 32'(irq_aout));
            end
        end else if (kind == "fill") begin
            // Same sample again until one write is held off
            tries = 0;
            waits = 0;
            while (waits == 0 && tries <= 2 ** fifo_addr_w) begin
                apb_transfer(1'b1, addr, data, rdata, err, waits);
                exp_duty.push_back(sample_duty(data, model_signed));
                tries++;
            end
            if (waits == 0) begin
                report_problem(name, "no sample write stalled although the FIFO filled up");
            end else if (waits < int'(expect_val)) begin
                report_value(name, "stall cycles", expect_val, 32'(waits));
            end
        end else if (kind == "audio") begin
            // Poll the running bit of the status byte
            rdata = 32'h8000_0000;
            while (rdata[31]) begin
                apb_transfer(1'b0, 32'h0, 32'h0, rdata, err, waits);
            end
            total     = high_cycles - high_base;
            high_base = high_cycles;
            if (total != int'(data)) begin
                report_value(name, "audio high cycles", data, 32'(total));
            end
            // Each sample gives interval + 1 pulses of its duty, none for duty 0
            foreach (exp_duty[k]) begin
                for (int r = 0; r <= model_interval; r++) begin
                    if (exp_duty[k] != 0) begin
                        exp_pulses.push_back(exp_duty[k]);
                    end
                end
            end
            if (pulse_widths.size() != exp_pulses.size()) begin
                report_value(name, "audio pulse count", 32'(exp_pulses.size()),
                             32'(pulse_widths.size()));
            end else begin
                pulse_bad = 1'b0;
                foreach (exp_pulses[k]) begin
                    if (!pulse_bad && pulse_widths[k] != exp_pulses[k]) begin
                        report_value(name, $sformatf("width of pulse %0d", k),
                                     32'(exp_pulses[k]), 32'(pulse_widths[k]));
                        pulse_bad = 1'b1;
                    end
                end
            end
            exp_duty.delete();
            pulse_widths.delete();
        end else begin
            report_problem(name, {"unknown operation kind ", kind});
        end

        tests_run++;
        if (test_bad) begin
            tests_failed++;
            $display("failed %s", name);
        end else begin
            $display("ok     %s", name);
        end
    endtask

    // ------------------------------------------------------------------
    // Watchdog and main sequence

    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk_sys);
            cycle_count++;
        end
        $display("Run did not finish within %0d cycles", cycle_limit);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        bit file_ok;
        rst_n_sys = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        load_ops(file_ok);
        if (!file_ok) begin
            $display("Could not read any operation from %s", input_path);
            $display("STATUS: FAIL");
        end else begin
            repeat (16) @(negedge clk_sys);
            rst_n_sys = 1'b1;
            @(negedge clk_sys);
            for (int i = 0; i < op_name.size(); i++) begin
                run_op(i);
            end
            $display("Tests: %0d run, %0d failed, %0d errors",
                     tests_run, tests_failed, error_count);
            if (error_count == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/aout_input.txt */
# name kind addr data expected, numbers in hex; kinds wr rd irq fill audio
# fill: data is the sample, expected the minimum stall cycles; audio: data is the high-cycle total
rd_reset        rd     0 00000000 00000000
irq_reset       irq    0 00000000 00000001
wr_ctrl         wr     0 ff013ffc 00000000
rd_ctrl         rd     0 00000000 00013000
rd_unmapped     rd     8 00000000 00000000
wr_unmapped     wr     c 00ff0001 00000000
rd_ctrl_kept    rd     0 00000000 00013000
wr_smp0         wr     4 ffff1234 00000000
wr_smp1         wr     4 00008000 00000000
wr_smp2         wr     4 0000ff00 00000000
irq_level3      irq    0 00000000 00000001
wr_smp3         wr     4 00000080 00000000
irq_level4      irq    0 00000000 00000000
rd_full         rd     0 00000000 44013000
wr_play         wr     0 00013001 00000000
fill_stall      fill   4 00004000 00000014
audio_unsigned  audio  0 00000422 00000000
wr_signed       wr     0 00013002 00000000
wr_ssmp0        wr     4 00000000 00000000
wr_ssmp1        wr     4 00007fff 00000000
wr_ssmp2        wr     4 00008000 00000000
wr_ssmp3        wr     4 0000c000 00000000
wr_play_signed  wr     0 00013003 00000000
audio_signed    audio  0 0000037e 00000000
rd_idle         rd     0 00000000 00013003
irq_idle        irq    0 00000000 00000001

/* project.f */
rtl/aout_pkg.sv
rtl/aout_apb_regs.sv
rtl/aout_sample_fifo.sv
rtl/aout_pwm.sv
rtl/aout_top.sv
verification/tb_aout.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the audio output testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

build_out=$(verilator --binary --assert -Wno-fatal --top-module tb_aout -f project.f 2>&1)
status=$?
echo "$build_out"
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_aout 2>&1)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "STATUS: PASS" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi
